/* src.f */
+incdir+include
verilog/render_pkg.sv
verilog/anim_timer.sv
verilog/tile_lookup.sv
verilog/sprite_unit.sv
verilog/pixel_mux.sv
verilog/renderer.sv
bench/renderer_checker.sv
bench/tb_renderer.sv

/* Makefile */
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_renderer: src.f $(SRCS) include/render_cfg.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_renderer -f src.f

run: obj_dir/Vtb_renderer
	./obj_dir/Vtb_renderer +verilator+error+limit+10000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module tb_renderer
    import render_pkg::*;
();

    localparam int NUM_TESTS   = 8;
    localparam int CLK_NS      = 100;
    localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 100) * CLK_NS;
    localparam int MAP_W       = `TILE_NUM;
    localparam int XW          = `X_BITS;
    localparam int YW          = `Y_BITS;

    logic             clk;
    logic             rst;
    logic             to_display;
    game_state_t      game_state;
    logic [XW-1:0]    x;
    logic [YW-1:0]    y;
    logic [MAP_W-1:0] tilemap_walls;
    logic [MAP_W-1:0] tilemap_dots;
    logic [MAP_W-1:0] tilemap_big_dots;
    logic [XW-1:0]    player_x;
    logic [YW-1:0]    player_y;
    dir_t             player_dir;
    logic [XW-1:0]    ghost1_x;
    logic [YW-1:0]    ghost1_y;
    dir_t             ghost1_dir;
    logic [XW-1:0]    ghost2_x;
    logic [YW-1:0]    ghost2_y;
    dir_t             ghost2_dir;
    chan_t            r;
    chan_t            g;
    chan_t            b;
    int               pass_count = 0;
    int               fail_count = 0;
    int               errs_seen = 0;

    renderer i_dut (.*);

    bind renderer renderer_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    task automatic drive_pixel(input int px, input int py);
        @(posedge clk);
        x <= XW'(px);
        y <= YW'(py);
    endtask

    task automatic randomize_scene();
        tilemap_walls    <= MAP_W'({$urandom, $urandom});
        tilemap_dots     <= MAP_W'({$urandom, $urandom});
        tilemap_big_dots <= MAP_W'({$urandom, $urandom});
        player_x         <= XW'($urandom);
        player_y         <= YW'($urandom);
        player_dir       <= dir_t'($urandom % 4);
        ghost1_x         <= XW'($urandom);
        ghost1_y         <= YW'($urandom);
        ghost1_dir       <= dir_t'($urandom % 4);
        ghost2_x         <= XW'($urandom);
        ghost2_y         <= YW'($urandom);
        ghost2_dir       <= dir_t'($urandom % 4);
    endtask

    task automatic place_sprites(input int sx, input int sy, input dir_t d,
                                 input int g1x, input int g1y, input int g2x, input int g2y);
        player_x   <= XW'(sx);
        player_y   <= YW'(sy);
        player_dir <= d;
        ghost1_x   <= XW'(g1x);
        ghost1_y   <= YW'(g1y);
        ghost2_x   <= XW'(g2x);
        ghost2_y   <= YW'(g2y);
    endtask

    // lets the last pixel reach the output and its check run before counting
    task automatic finish_test(input string name);
        int errs_now;
        repeat (2) @(posedge clk);
        @(negedge clk);
        errs_now = i_dut.u_checker.err_count;
        if (errs_now == errs_seen) begin
            pass_count++;
            $display("test %-16s ok", name);
        end else begin
            fail_count++;
            $display("test %-16s failed with %0d assertion errors", name, errs_now - errs_seen);
        end
        errs_seen = errs_now;
    endtask

    // two passes 80 cycles apart see every pixel in both frames
    task automatic test_player(input dir_t d);
        int sx;
        int sy;
        sx = $urandom % 49;
        sy = $urandom % 33;
        @(posedge clk);
        tilemap_walls    <= '0;
        tilemap_dots     <= '0;
        tilemap_big_dots <= '0;
        place_sprites(sx, sy, d, 56, 40, 56, 40);
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < 64; k++) begin
                drive_pixel(sx + k % 8, sy + k / 8);
            end
            repeat (16) @(posedge clk);
        end
        finish_test($sformatf("player %s", d.name()));
    endtask

    initial begin
        void'($urandom(93));
        rst              = 1'b1;
        to_display       = 1'b0;
        game_state       = gs_playing;
        x                = '0;
        y                = '0;
        tilemap_walls    = '0;
        tilemap_dots     = '0;
        tilemap_big_dots = '0;
        player_x         = '0;
        player_y         = '0;
        player_dir       = dir_left;
        ghost1_x         = '0;
        ghost1_y         = '0;
        ghost1_dir       = dir_left;
        ghost2_x         = '0;
        ghost2_y         = '0;
        ghost2_dir       = dir_left;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 20; i++) begin
            drive_pixel($urandom % 64, $urandom % 48);
            randomize_scene();
        end
        finish_test("blanking");

        @(posedge clk);
        to_display <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            drive_pixel($urandom % 64, $urandom % 48);
            randomize_scene();
            if (i % 2 == 0) begin
                game_state <= gs_idle;
            end else begin
                game_state <= gs_over;
            end
        end
        finish_test("debug state");

        // wall at tile 9 under the player, big dot at 10, dot at 11, 12 open
        @(posedge clk);
        game_state       <= gs_playing;
        tilemap_walls    <= MAP_W'(1) << 9;
        tilemap_big_dots <= (MAP_W'(1) << 10) | (MAP_W'(1) << 9);
        tilemap_dots     <= (MAP_W'(1) << 11) | (MAP_W'(1) << 9);
        place_sprites(4, 8, dir_left, 56, 40, 56, 40);
        for (int yy = 9; yy < 14; yy++) begin
            for (int xx = 4; xx < 36; xx++) begin
                drive_pixel(xx, yy);
            end
        end
        finish_test("walls and dots");

        for (int k = 0; k < 4; k++) begin
            test_player(dir_t'(k));
        end

        // ghost2 under ghost1 under the player, then the ghost1 skirt row over several frames
        @(posedge clk);
        place_sprites(25, 21, dir_t'($urandom % 4), 20, 16, 23, 18);
        for (int yy = 16; yy < 28; yy++) begin
            for (int xx = 20; xx < 31; xx++) begin
                drive_pixel(xx, yy);
            end
        end
        for (int rep = 0; rep < 4; rep++) begin
            for (int xx = 20; xx < 28; xx++) begin
                drive_pixel(xx, 23);
            end
        end
        finish_test("ghost priority");

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/renderer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module renderer_checker
    import render_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 to_display,
    input game_state_t          game_state,
    input logic [`X_BITS-1:0]   x,
    input logic [`Y_BITS-1:0]   y,
    input logic [`TILE_NUM-1:0] tilemap_walls,
    input logic [`TILE_NUM-1:0] tilemap_dots,
    input logic [`TILE_NUM-1:0] tilemap_big_dots,
    input logic [`X_BITS-1:0]   player_x,
    input logic [`Y_BITS-1:0]   player_y,
    input dir_t                 player_dir,
    input logic [`X_BITS-1:0]   ghost1_x,
    input logic [`Y_BITS-1:0]   ghost1_y,
    input logic [`X_BITS-1:0]   ghost2_x,
    input logic [`Y_BITS-1:0]   ghost2_y,
    input chan_t                r,
    input chan_t                g,
    input chan_t                b
);

    int          err_count = 0;
    int          cyc = 0;
    logic        seen_rst = 1'b0;
    logic [11:0] exp_rgb;
    logic [11:0] exp_q = 12'h000;
    logic        blank_q = 1'b0;
    logic        debug_q = 1'b0;
    logic        frame_m;
    logic        on_map;
    int          px;
    int          py;
    int          idx;
    int          tu;
    int          tv;

    function automatic logic inside_box(input int cx, input int cy, input int sx, input int sy);
        return (cx >= sx) && (cx < sx + `TILE_SIZE) && (cy >= sy) && (cy < sy + `TILE_SIZE);
    endfunction

    function automatic logic in_square(input int a, input int b, input int lo, input int hi);
        return (a >= lo) && (a <= hi) && (b >= lo) && (b <= hi);
    endfunction

    // disk of radius 3.5 pixels around the tile centre
    function automatic logic in_circle(input int a, input int b);
        int ca;
        int cb;
        ca = 2 * a - 7;
        cb = 2 * b - 7;
        return (ca * ca + cb * cb) <= 49;
    endfunction

    // map the screen offset back to the left facing sprite
    function automatic logic player_on(input int u, input int v, input dir_t d, input logic f);
        int a;
        int c;
        int half;
        a = (d == dir_left) ? u : (d == dir_right) ? 7 - u : (d == dir_down) ? 7 - v : v;
        c = (d == dir_left || d == dir_right) ? v : (d == dir_down) ? u : 7 - u;
        half = (2 * c - 7 < 0) ? 7 - 2 * c : 2 * c - 7;
        if (!f && a <= 3 && half <= 7 - 2 * a) begin
            return 1'b0;
        end
        return in_circle(a, c);
    endfunction

    function automatic logic ghost_on(input int u, input int v, input logic f);
        if (v == 7) begin
            return (u % 2) == int'(f);
        end
        if (v >= 3) begin
            return 1'b1;
        end
        return in_circle(u, v);
    endfunction

    always_comb begin
        px      = int'(x);
        py      = int'(y);
        tu      = px % `TILE_SIZE;
        tv      = py % `TILE_SIZE;
        idx     = px / `TILE_SIZE + (py / `TILE_SIZE) * `TILE_COLS;
        on_map  = (py / `TILE_SIZE) < `TILE_ROWS;
        frame_m = ((cyc / `ANIM_PERIOD) % 2) == 1;
        if (!to_display) begin
            exp_rgb = 12'h000;
        end else if (game_state != gs_playing) begin
            exp_rgb = `DEBUG_RGB;
        end else if (on_map && tilemap_walls[idx]) begin
            exp_rgb = `WALL_RGB;
        end else if (inside_box(px, py, int'(player_x), int'(player_y))) begin
            exp_rgb = player_on(px - int'(player_x), py - int'(player_y), player_dir, frame_m)
                      ? `PLAYER_RGB : 12'h000;
        end else if (inside_box(px, py, int'(ghost1_x), int'(ghost1_y))) begin
            exp_rgb = ghost_on(px - int'(ghost1_x), py - int'(ghost1_y), frame_m)
                      ? `GHOST1_RGB : 12'h000;
        end else if (inside_box(px, py, int'(ghost2_x), int'(ghost2_y))) begin
            exp_rgb = ghost_on(px - int'(ghost2_x), py - int'(ghost2_y), frame_m)
                      ? `GHOST2_RGB : 12'h000;
        end else if (on_map && tilemap_big_dots[idx]) begin
            exp_rgb = in_square(tu, tv, 2, 5) ? `DOT_RGB : 12'h000;
        end else if (on_map && tilemap_dots[idx]) begin
            exp_rgb = in_square(tu, tv, 3, 4) ? `DOT_RGB : 12'h000;
        end else begin
            exp_rgb = 12'h000;
        end
    end

    // cycle count since reset gives the animation frame of each sampled pixel
    always @(posedge clk) begin
        if (rst) begin
            seen_rst <= 1'b1;
            cyc      <= 0;
            exp_q    <= 12'h000;
            blank_q  <= 1'b0;
            debug_q  <= 1'b0;
        end else begin
            cyc     <= cyc + 1;
            exp_q   <= exp_rgb;
            blank_q <= !to_display;
            debug_q <= to_display && (game_state != gs_playing);
        end
    end

    a_colour: assert property (@(posedge clk) seen_rst |-> ({r, g, b} == exp_q))
        else begin
            err_count++;
            $error("Error at %0t: colour %h, expected %h", $time, $sampled({r, g, b}),
                   $sampled(exp_q));
        end

    a_blank: assert property (@(posedge clk) blank_q |-> ({r, g, b} == 12'h000))
        else begin
            err_count++;
            $error("Error at %0t: blanked pixel shows colour %h", $time, $sampled({r, g, b}));
        end

    a_debug: assert property (@(posedge clk) debug_q |-> ({r, g, b} == `DEBUG_RGB))
        else begin
            err_count++;
            $error("Error at %0t: debug colour expected, got %h", $time, $sampled({r, g, b}));
        end

endmodule

`default_nettype wire

/* verilog/renderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module renderer
    import render_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 to_display,
    input  game_state_t          game_state,
    input  logic [`X_BITS-1:0]   x,
    input  logic [`Y_BITS-1:0]   y,
    input  logic [`TILE_NUM-1:0] tilemap_walls,
    input  logic [`TILE_NUM-1:0] tilemap_dots,
    input  logic [`TILE_NUM-1:0] tilemap_big_dots,
    input  logic [`X_BITS-1:0]   player_x,
    input  logic [`Y_BITS-1:0]   player_y,
    input  dir_t                 player_dir,
    input  logic [`X_BITS-1:0]   ghost1_x,
    input  logic [`Y_BITS-1:0]   ghost1_y,
    input  dir_t                 ghost1_dir,
    input  logic [`X_BITS-1:0]   ghost2_x,
    input  logic [`Y_BITS-1:0]   ghost2_y,
    input  dir_t                 ghost2_dir,
    output chan_t                r,
    output chan_t                g,
    output chan_t                b
);

    logic                  frame;
    logic [`TILE_LOG2-1:0] tile_u;
    logic [`TILE_LOG2-1:0] tile_v;
    logic                  wall;
    logic                  dot;
    logic                  big_dot;
    logic                  player_hit;
    logic                  player_pix;
    logic                  ghost1_hit;
    logic                  ghost1_pix;
    logic                  ghost2_hit;
    logic                  ghost2_pix;

    // one timer paces both the player mouth and the ghost skirts
    anim_timer u_anim_timer (
        .clk   (clk),
        .rst   (rst),
        .frame (frame)
    );

    tile_lookup u_tile_lookup (
        .x        (x),
        .y        (y),
        .walls    (tilemap_walls),
        .dots     (tilemap_dots),
        .big_dots (tilemap_big_dots),
        .tile_u   (tile_u),
        .tile_v   (tile_v),
        .wall     (wall),
        .dot      (dot),
        .big_dot  (big_dot)
    );

    sprite_unit #(.GHOST(1'b0)) u_player (
        .x     (x),
        .y     (y),
        .spr_x (player_x),
        .spr_y (player_y),
        .dir   (player_dir),
        .frame (frame),
        .hit   (player_hit),
        .pix   (player_pix)
    );

    sprite_unit #(.GHOST(1'b1)) u_ghost1 (
        .x     (x),
        .y     (y),
        .spr_x (ghost1_x),
        .spr_y (ghost1_y),
        .dir   (ghost1_dir),
        .frame (frame),
        .hit   (ghost1_hit),
        .pix   (ghost1_pix)
    );

    sprite_unit #(.GHOST(1'b1)) u_ghost2 (
        .x     (x),
        .y     (y),
        .spr_x (ghost2_x),
        .spr_y (ghost2_y),
        .dir   (ghost2_dir),
        .frame (frame),
        .hit   (ghost2_hit),
        .pix   (ghost2_pix)
    );

    pixel_mux u_pixel_mux (
        .clk        (clk),
        .rst        (rst),
        .to_display (to_display),
        .game_state (game_state),
        .tile_u     (tile_u),
        .tile_v     (tile_v),
        .wall       (wall),
        .dot        (dot),
        .big_dot    (big_dot),
        .player_hit (player_hit),
        .player_pix (player_pix),
        .ghost1_hit (ghost1_hit),
        .ghost1_pix (ghost1_pix),
        .ghost2_hit (ghost2_hit),
        .ghost2_pix (ghost2_pix),
        .r          (r),
        .g          (g),
        .b          (b)
    );

endmodule

`default_nettype wire

/* verilog/pixel_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module pixel_mux
    import render_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  to_display,
    input  game_state_t           game_state,
    input  logic [`TILE_LOG2-1:0] tile_u,
    input  logic [`TILE_LOG2-1:0] tile_v,
    input  logic                  wall,
    input  logic                  dot,
    input  logic                  big_dot,
    input  logic                  player_hit,
    input  logic                  player_pix,
    input  logic                  ghost1_hit,
    input  logic                  ghost1_pix,
    input  logic                  ghost2_hit,
    input  logic                  ghost2_pix,
    output chan_t                 r,
    output chan_t                 g,
    output chan_t                 b
);

    logic [11:0] rgb;
    logic        big_sq;
    logic        small_sq;

    assign big_sq   = (tile_u >= 2) && (tile_u <= 5) && (tile_v >= 2) && (tile_v <= 5);
    assign small_sq = (tile_u >= 3) && (tile_u <= 4) && (tile_v >= 3) && (tile_v <= 4);

    // layers run from top to bottom and a sprite hides the dots under its box
    always_comb begin
        if (!to_display) begin
            rgb = 12'h000;
        end else if (game_state != gs_playing) begin
            rgb = `DEBUG_RGB;
        end else if (wall) begin
            rgb = `WALL_RGB;
        end else if (player_hit) begin
            rgb = player_pix ? `PLAYER_RGB : 12'h000;
        end else if (ghost1_hit) begin
            rgb = ghost1_pix ? `GHOST1_RGB : 12'h000;
        end else if (ghost2_hit) begin
            rgb = ghost2_pix ? `GHOST2_RGB : 12'h000;
        end else if (big_dot) begin
            rgb = big_sq ? `DOT_RGB : 12'h000;
        end else if (dot) begin
            rgb = small_sq ? `DOT_RGB : 12'h000;
        end else begin
            rgb = 12'h000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            r <= rgb[11:8];
            g <= rgb[7:4];
            b <= rgb[3:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/sprite_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module sprite_unit
    import render_pkg::*;
#(
    parameter bit GHOST = 1'b0
) (
    input  logic [`X_BITS-1:0] x,
    input  logic [`Y_BITS-1:0] y,
    input  logic [`X_BITS-1:0] spr_x,
    input  logic [`Y_BITS-1:0] spr_y,
    input  dir_t               dir,
    input  logic               frame,
    output logic               hit,
    output logic               pix
);

    localparam int EDGE = `TILE_SIZE - 1;

    logic [`X_BITS-1:0]    dx;
    logic [`Y_BITS-1:0]    dy;
    logic [`TILE_LOG2-1:0] u;
    logic [`TILE_LOG2-1:0] v;
    logic [`TILE_LOG2-1:0] ru;
    logic [`TILE_LOG2-1:0] rv;

    // the round body is centred between the middle pixels of the tile
    function automatic logic in_disk(input logic [`TILE_LOG2-1:0] a,
                                     input logic [`TILE_LOG2-1:0] b);
        int da;
        int db;
        da = 2 * int'(a) - EDGE;
        db = 2 * int'(b) - EDGE;
        return (da * da + db * db) <= EDGE * EDGE;
    endfunction

    // the mouth is a wedge that opens to the left and is widest at the left edge
    function automatic logic in_mouth(input logic [`TILE_LOG2-1:0] a,
                                      input logic [`TILE_LOG2-1:0] b);
        int db;
        db = 2 * int'(b) - EDGE;
        if (db < 0) begin
            db = -db;
        end
        return (int'(a) <= 3) && (db <= EDGE - 2 * int'(a));
    endfunction

    assign dx = x - spr_x;
    assign dy = y - spr_y;

    assign hit = (x >= spr_x) && (dx < `TILE_SIZE) && (y >= spr_y) && (dy < `TILE_SIZE);

    assign u = dx[`TILE_LOG2-1:0];
    assign v = dy[`TILE_LOG2-1:0];

    // ghosts always face the same way on screen
    always_comb begin
        ru = u;
        rv = v;
        if (!GHOST) begin
            case (dir)
                dir_right: begin
                    ru = `TILE_LOG2'(EDGE) - u;
                    rv = v;
                end
                dir_down: begin
                    ru = `TILE_LOG2'(EDGE) - v;
                    rv = u;
                end
                dir_up: begin
                    ru = v;
                    rv = `TILE_LOG2'(EDGE) - u;
                end
                default: begin
                    ru = u;
                    rv = v;
                end
            endcase
        end
    end

    always_comb begin
        if (GHOST) begin
            if (rv == `TILE_LOG2'(EDGE)) begin
                // the fringe of the skirt row shifts by one pixel each frame
                pix = (ru[0] == frame);
            end else if (rv >= 3) begin
                pix = 1'b1;
            end else begin
                pix = in_disk(ru, rv);
            end
        end else begin
            pix = in_disk(ru, rv) && !(!frame && in_mouth(ru, rv));
        end
    end

endmodule

`default_nettype wire

/* verilog/tile_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module tile_lookup (
    input  logic [`X_BITS-1:0]    x,
    input  logic [`Y_BITS-1:0]    y,
    input  logic [`TILE_NUM-1:0]  walls,
    input  logic [`TILE_NUM-1:0]  dots,
    input  logic [`TILE_NUM-1:0]  big_dots,
    output logic [`TILE_LOG2-1:0] tile_u,
    output logic [`TILE_LOG2-1:0] tile_v,
    output logic                  wall,
    output logic                  dot,
    output logic                  big_dot
);

    localparam int IDX_BITS = $clog2(`TILE_NUM);

    logic [`X_BITS-`TILE_LOG2-1:0] col;
    logic [`Y_BITS-`TILE_LOG2-1:0] row;
    logic [IDX_BITS-1:0]           idx;
    logic                          in_map;

    // tile edge is a power of two, so the split is a plain bit slice
    assign col    = x[`X_BITS-1:`TILE_LOG2];
    assign row    = y[`Y_BITS-1:`TILE_LOG2];
    assign tile_u = x[`TILE_LOG2-1:0];
    assign tile_v = y[`TILE_LOG2-1:0];

    assign idx = IDX_BITS'(col) + IDX_BITS'(row) * IDX_BITS'(`TILE_COLS);

    // rows below the maze read as empty tiles
    assign in_map = (row < `TILE_ROWS);

    assign wall    = in_map ? walls[idx]    : 1'b0;
    assign dot     = in_map ? dots[idx]     : 1'b0;
    assign big_dot = in_map ? big_dots[idx] : 1'b0;

endmodule

`default_nettype wire

/* verilog/anim_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "render_cfg.svh"

module anim_timer (
    input  logic clk,
    input  logic rst,
    output logic frame
);

    localparam int CNT_BITS = $clog2(`ANIM_PERIOD);

    logic [CNT_BITS-1:0] cnt;

    // frame flips once per full count, so one frame lasts ANIM_PERIOD cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            frame <= 1'b0;
        end else if (cnt == CNT_BITS'(`ANIM_PERIOD - 1)) begin
            cnt   <= '0;
            frame <= ~frame;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/render_pkg.sv */
`default_nettype none

package render_pkg;

    // sprites are drawn facing left and the other directions rotate that image
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    typedef enum logic [2:0] {
        gs_idle    = 3'd0,
        gs_playing = 3'd1,
        gs_over    = 3'd2
    } game_state_t;

    typedef logic [3:0] chan_t;

endpackage

`default_nettype wire

/* include/render_cfg.svh */
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// tiles and sprites share one square edge
`define TILE_SIZE 8
`define TILE_LOG2 3

// the maze is 8 by 6 tiles and each map holds one bit per tile
`define TILE_COLS 8
`define TILE_ROWS 6
`define TILE_NUM (`TILE_COLS * `TILE_ROWS)

// pixel coordinates cover the 64 by 48 screen
`define X_BITS 6
`define Y_BITS 6

// clock cycles spent in each animation frame
`define ANIM_PERIOD 16

// each colour packs r, g and b as one hex digit per channel
`define WALL_RGB   12'h00F
`define PLAYER_RGB 12'hFF0
`define GHOST1_RGB 12'hF00
`define GHOST2_RGB 12'hF8F
`define DOT_RGB    12'hFFF
`define DEBUG_RGB  12'h74F

`endif
